//--- dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// address split is tag | index | offset
`define DC_ADDR_W   32
`define DC_DATA_W   64
`define DC_TAG_W    22
`define DC_INDEX_W  6
`define DC_OFFSET_W 4

`define DC_WAYS     2
`define DC_BEATS    2  // words per line

`endif

//--- logic/dcache_addr_pkg.sv
`default_nettype none
`include "dcache_macros.svh"

package dcache_addr_pkg;

  typedef logic [`DC_ADDR_W-1:0] addr_t;
  typedef logic [`DC_TAG_W-1:0] tag_t;
  typedef logic [`DC_INDEX_W-1:0] index_t;

  typedef logic [`DC_DATA_W-1:0] word_t;
  typedef logic [`DC_DATA_W/8-1:0] strb_t;  // one bit per byte
  typedef logic [`DC_BEATS*`DC_DATA_W-1:0] line_t;

  typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

endpackage

`default_nettype wire

//--- logic/dcache_bus_pkg.sv
`default_nettype none
`include "dcache_macros.svh"

package dcache_bus_pkg;

  // one cpu store
  typedef struct packed {
    dcache_addr_pkg::word_t data;
    dcache_addr_pkg::strb_t strb;
  } wr_data_t;

  typedef struct packed {
    dcache_addr_pkg::word_t data;
    logic last;
  } mem_w_t;

  typedef struct packed {
    dcache_addr_pkg::word_t data;
    logic last;
  } mem_r_t;

  // update of one way, applied on the next edge
  typedef struct packed {
    dcache_addr_pkg::index_t index;
    logic [$clog2(`DC_BEATS)-1:0] word_sel;
    dcache_addr_pkg::strb_t strb;
    dcache_addr_pkg::word_t data;
    dcache_addr_pkg::tag_t tag;
    logic write_tag;
    logic set_valid;
    logic clear_valid;
    logic set_dirty;
    logic clear_dirty;
  } way_wr_t;

endpackage

`default_nettype wire

//--- logic/dcache_way.sv
`default_nettype none
`include "dcache_macros.svh"

module dcache_way (
  input  wire                            clk,
  input  wire                            rst,
  input  wire dcache_addr_pkg::index_t   lookup_index_i,
  input  wire dcache_addr_pkg::tag_t     lookup_tag_i,
  input  wire                            wr_en_i,
  input  wire dcache_bus_pkg::way_wr_t   wr_i,
  output logic                           hit_o,
  output dcache_addr_pkg::tag_t          tag_o,
  output logic                           dirty_o,
  output dcache_addr_pkg::line_t         line_o
);

  localparam int SETS = 1 << `DC_INDEX_W;
  localparam int WORD_BYTES = `DC_DATA_W / 8;

  dcache_addr_pkg::tag_t tag_mem [SETS];
  dcache_addr_pkg::line_t data_mem [SETS];
  logic [SETS-1:0] valid_q;
  logic [SETS-1:0] dirty_q;

  logic rd_valid_q;
  dcache_addr_pkg::tag_t look_tag_q;  // tag of the lookup in flight

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int w = 0; w < `DC_BEATS; w++) begin
        for (int b = 0; b < WORD_BYTES; b++) begin
          if (wr_i.word_sel == w && wr_i.strb[b]) begin
            data_mem[wr_i.index][w*`DC_DATA_W + b*8 +: 8] <= wr_i.data[b*8 +: 8];
          end
        end
      end
      if (wr_i.write_tag) begin
        tag_mem[wr_i.index] <= wr_i.tag;
      end
    end
    // registered read, one cycle
    line_o <= data_mem[lookup_index_i];
    tag_o <= tag_mem[lookup_index_i];
    rd_valid_q <= valid_q[lookup_index_i];
    dirty_o <= dirty_q[lookup_index_i];
    look_tag_q <= lookup_tag_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (wr_en_i) begin
      if (wr_i.set_valid) begin
        valid_q[wr_i.index] <= 1'b1;
      end else if (wr_i.clear_valid) begin
        valid_q[wr_i.index] <= 1'b0;
      end
      if (wr_i.set_dirty) begin
        dirty_q[wr_i.index] <= 1'b1;
      end else if (wr_i.clear_dirty) begin
        dirty_q[wr_i.index] <= 1'b0;
      end
    end
  end

  assign hit_o = rd_valid_q && tag_o == look_tag_q;

endmodule

`default_nettype wire

//--- logic/dcache_way_select.sv
`default_nettype none
`include "dcache_macros.svh"

module dcache_way_select (
  input  wire                            clk,
  input  wire                            rst,
  input  wire [`DC_WAYS-1:0]             hit_i,
  input  wire dcache_addr_pkg::tag_t     tag_i [`DC_WAYS],
  input  wire [`DC_WAYS-1:0]             dirty_i,
  input  wire dcache_addr_pkg::line_t    line_i [`DC_WAYS],
  input  wire dcache_addr_pkg::way_t     sel_way_i,
  output logic                           hit_o,
  output dcache_addr_pkg::way_t          hit_way_o,
  output dcache_addr_pkg::way_t          victim_way_o,
  output logic                           victim_dirty_o,
  output dcache_addr_pkg::tag_t          victim_tag_o,
  output dcache_addr_pkg::line_t         line_o
);

  dcache_addr_pkg::way_t victim_q;

  // free-running counter stands in for random replacement
  always_ff @(posedge clk) begin
    if (rst) begin
      victim_q <= '0;
    end else begin
      victim_q <= victim_q + 1'b1;
    end
  end

  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (hit_i[w]) begin
        hit_way_o = dcache_addr_pkg::way_t'(w);
      end
    end
  end

  assign hit_o = |hit_i;

  assign victim_way_o = victim_q;
  assign victim_dirty_o = dirty_i[victim_q];
  assign victim_tag_o = tag_i[victim_q];

  assign line_o = line_i[sel_way_i];

endmodule

`default_nettype wire

//--- logic/dcache_ctrl.sv
`default_nettype none
`include "dcache_macros.svh"

module dcache_ctrl (
  input  wire                            clk,
  input  wire                            rst,
  // cpu side
  input  wire                            rd_req_valid_i,
  output logic                           rd_req_ready_o,
  input  wire dcache_addr_pkg::addr_t    rd_req_addr_i,
  output logic                           rd_rsp_valid_o,
  input  wire                            rd_rsp_ready_i,
  output dcache_addr_pkg::word_t         rd_rsp_data_o,
  input  wire                            wr_req_valid_i,
  output logic                           wr_req_ready_o,
  input  wire dcache_addr_pkg::addr_t    wr_req_addr_i,
  input  wire                            wr_data_valid_i,
  output logic                           wr_data_ready_o,
  input  wire dcache_bus_pkg::wr_data_t  wr_data_i,
  output logic                           wr_done_valid_o,
  input  wire                            wr_done_ready_i,
  // memory side
  output logic                           mem_ar_valid_o,
  input  wire                            mem_ar_ready_i,
  output dcache_addr_pkg::addr_t         mem_ar_addr_o,
  input  wire                            mem_r_valid_i,
  output logic                           mem_r_ready_o,
  input  wire dcache_bus_pkg::mem_r_t    mem_r_i,
  output logic                           mem_aw_valid_o,
  input  wire                            mem_aw_ready_i,
  output dcache_addr_pkg::addr_t         mem_aw_addr_o,
  output logic                           mem_w_valid_o,
  input  wire                            mem_w_ready_i,
  output dcache_bus_pkg::mem_w_t         mem_w_o,
  input  wire                            mem_b_valid_i,
  output logic                           mem_b_ready_o,
  // ways
  output dcache_addr_pkg::index_t        lookup_index_o,
  output dcache_addr_pkg::tag_t          lookup_tag_o,
  output dcache_bus_pkg::way_wr_t        way_wr_o,
  output logic [`DC_WAYS-1:0]            way_wr_en_o,
  output dcache_addr_pkg::way_t          sel_way_o,
  input  wire                            hit_i,
  input  wire dcache_addr_pkg::way_t     hit_way_i,
  input  wire dcache_addr_pkg::way_t     victim_way_i,
  input  wire                            victim_dirty_i,
  input  wire dcache_addr_pkg::tag_t     victim_tag_i,
  input  wire dcache_addr_pkg::line_t    line_i
);

  localparam int WORD_LSB = $clog2(`DC_DATA_W / 8);
  localparam int BEAT_W = $clog2(`DC_BEATS);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HIT,
    S_WB_ADDR,
    S_WB_DATA,
    S_WB_RESP,
    S_RF_ADDR,
    S_RF_DATA
  } state_t;

  state_t state_q;
  dcache_addr_pkg::addr_t addr_q;
  dcache_addr_pkg::addr_t aw_addr_q;
  dcache_addr_pkg::way_t way_q;  // victim being replaced
  logic [BEAT_W-1:0] beat_q;
  logic is_wr_q;
  logic lookup_q;  // way outputs not yet valid for addr_q
  logic got_q;  // store data buffered
  dcache_bus_pkg::wr_data_t wdata_q;

  dcache_bus_pkg::wr_data_t wdata;
  logic [BEAT_W-1:0] word_sel;
  logic rd_acc, wr_acc, wd_xfer, r_xfer, rsp_xfer;
  logic last_beat, look_done, do_merge;

  assign rd_req_ready_o = state_q == S_IDLE;
  assign wr_req_ready_o = state_q == S_IDLE && !rd_req_valid_i;  // read wins

  assign rd_acc = rd_req_valid_i && rd_req_ready_o;
  assign wr_acc = wr_req_valid_i && wr_req_ready_o;
  assign wd_xfer = wr_data_valid_i && wr_data_ready_o;
  assign r_xfer = mem_r_valid_i && mem_r_ready_o;
  assign rsp_xfer = (rd_rsp_valid_o && rd_rsp_ready_i) || (wr_done_valid_o && wr_done_ready_i);
  assign last_beat = beat_q == BEAT_W'(`DC_BEATS - 1);

  assign lookup_index_o = addr_q[`DC_OFFSET_W +: `DC_INDEX_W];
  assign lookup_tag_o = addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign word_sel = addr_q[WORD_LSB +: BEAT_W];
  assign sel_way_o = (state_q == S_HIT) ? hit_way_i : way_q;

  // lookup result valid and no response pending
  assign look_done = state_q == S_HIT && !lookup_q && !rd_rsp_valid_o && !wr_done_valid_o;
  assign wdata = got_q ? wdata_q : wr_data_i;
  assign do_merge = look_done && hit_i && is_wr_q && (got_q || wd_xfer);

  assign mem_aw_valid_o = state_q == S_WB_ADDR;
  assign mem_w_valid_o = state_q == S_WB_DATA;
  assign mem_b_ready_o = state_q == S_WB_RESP;
  assign mem_ar_valid_o = state_q == S_RF_ADDR;
  assign mem_r_ready_o = state_q == S_RF_DATA;

  assign mem_aw_addr_o = aw_addr_q;
  assign mem_ar_addr_o = {addr_q[`DC_ADDR_W-1:`DC_OFFSET_W], `DC_OFFSET_W'(0)};
  assign mem_w_o.data = line_i[beat_q * `DC_DATA_W +: `DC_DATA_W];  // low word first
  assign mem_w_o.last = last_beat;

  always_comb begin
    way_wr_o = '0;
    way_wr_en_o = '0;
    way_wr_o.index = lookup_index_o;
    way_wr_o.tag = lookup_tag_o;
    if (do_merge) begin
      way_wr_en_o[hit_way_i] = 1'b1;
      way_wr_o.word_sel = word_sel;
      way_wr_o.strb = wdata.strb;
      way_wr_o.data = wdata.data;
      way_wr_o.set_dirty = 1'b1;
    end else if (state_q == S_RF_DATA && r_xfer) begin
      way_wr_en_o[way_q] = 1'b1;
      way_wr_o.word_sel = beat_q;
      way_wr_o.strb = '1;
      way_wr_o.data = mem_r_i.data;
      way_wr_o.clear_valid = beat_q == '0;  // line invalid until last beat
      way_wr_o.clear_dirty = beat_q == '0;
      way_wr_o.write_tag = mem_r_i.last;
      way_wr_o.set_valid = mem_r_i.last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      way_q <= '0;
      beat_q <= '0;
      is_wr_q <= 1'b0;
      lookup_q <= 1'b0;
      got_q <= 1'b0;
      rd_rsp_valid_o <= 1'b0;
      wr_data_ready_o <= 1'b0;
      wr_done_valid_o <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (rd_acc || wr_acc) begin
            is_wr_q <= !rd_acc;
            lookup_q <= 1'b1;
            state_q <= S_HIT;
          end
        end
        S_HIT: begin
          lookup_q <= 1'b0;
          if (lookup_q) begin
            if (is_wr_q && !got_q) wr_data_ready_o <= 1'b1;
          end else if (rd_rsp_valid_o || wr_done_valid_o) begin
            if (rsp_xfer) begin
              rd_rsp_valid_o <= 1'b0;
              wr_done_valid_o <= 1'b0;
              state_q <= S_IDLE;
            end
          end else if (!hit_i) begin
            way_q <= victim_way_i;
            state_q <= victim_dirty_i ? S_WB_ADDR : S_RF_ADDR;
          end else if (!is_wr_q) begin
            rd_rsp_valid_o <= 1'b1;
          end else if (do_merge) begin
            got_q <= 1'b0;
            wr_done_valid_o <= 1'b1;
          end
        end
        S_WB_ADDR: if (mem_aw_ready_i) state_q <= S_WB_DATA;
        S_WB_DATA: begin
          if (mem_w_ready_i) begin
            beat_q <= last_beat ? '0 : beat_q + 1'b1;
            if (last_beat) state_q <= S_WB_RESP;
          end
        end
        S_WB_RESP: if (mem_b_valid_i) state_q <= S_RF_ADDR;
        S_RF_ADDR: if (mem_ar_ready_i) state_q <= S_RF_DATA;
        S_RF_DATA: begin
          if (r_xfer) begin
            beat_q <= beat_q + 1'b1;
            if (mem_r_i.last) begin
              beat_q <= '0;
              lookup_q <= 1'b1;  // second lookup hits the refilled line
              state_q <= S_HIT;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
      // store data may arrive in any state
      if (wd_xfer) begin
        wr_data_ready_o <= 1'b0;
        got_q <= !do_merge;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      addr_q <= rd_req_addr_i;
    end else if (wr_acc) begin
      addr_q <= wr_req_addr_i;
    end
    if (look_done && !hit_i) begin
      aw_addr_q <= {victim_tag_i, lookup_index_o, `DC_OFFSET_W'(0)};
    end
    if (look_done && hit_i && !is_wr_q) begin
      rd_rsp_data_o <= line_i[word_sel * `DC_DATA_W +: `DC_DATA_W];
    end
    if (wd_xfer) begin
      wdata_q <= wr_data_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/dcache_top.sv
`default_nettype none
`include "dcache_macros.svh"

module dcache_top (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            rd_req_valid_i,
  output logic                           rd_req_ready_o,
  input  wire dcache_addr_pkg::addr_t    rd_req_addr_i,
  output logic                           rd_rsp_valid_o,
  input  wire                            rd_rsp_ready_i,
  output dcache_addr_pkg::word_t         rd_rsp_data_o,
  input  wire                            wr_req_valid_i,
  output logic                           wr_req_ready_o,
  input  wire dcache_addr_pkg::addr_t    wr_req_addr_i,
  input  wire                            wr_data_valid_i,
  output logic                           wr_data_ready_o,
  input  wire dcache_bus_pkg::wr_data_t  wr_data_i,
  output logic                           wr_done_valid_o,
  input  wire                            wr_done_ready_i,
  output logic                           mem_ar_valid_o,
  input  wire                            mem_ar_ready_i,
  output dcache_addr_pkg::addr_t         mem_ar_addr_o,
  input  wire                            mem_r_valid_i,
  output logic                           mem_r_ready_o,
  input  wire dcache_bus_pkg::mem_r_t    mem_r_i,
  output logic                           mem_aw_valid_o,
  input  wire                            mem_aw_ready_i,
  output dcache_addr_pkg::addr_t         mem_aw_addr_o,
  output logic                           mem_w_valid_o,
  input  wire                            mem_w_ready_i,
  output dcache_bus_pkg::mem_w_t         mem_w_o,
  input  wire                            mem_b_valid_i,
  output logic                           mem_b_ready_o
);

  dcache_addr_pkg::index_t lookup_index;
  dcache_addr_pkg::tag_t lookup_tag;
  dcache_bus_pkg::way_wr_t way_wr;
  logic [`DC_WAYS-1:0] way_wr_en;
  logic [`DC_WAYS-1:0] way_hit;
  logic [`DC_WAYS-1:0] way_dirty;
  dcache_addr_pkg::tag_t way_tag [`DC_WAYS];
  dcache_addr_pkg::line_t way_line [`DC_WAYS];

  dcache_addr_pkg::way_t sel_way, hit_way, victim_way;
  dcache_addr_pkg::tag_t victim_tag;
  dcache_addr_pkg::line_t sel_line;
  logic hit, victim_dirty;

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    dcache_way u_way (
      .clk            (clk),
      .rst            (rst),
      .lookup_index_i (lookup_index),
      .lookup_tag_i   (lookup_tag),
      .wr_en_i        (way_wr_en[w]),
      .wr_i           (way_wr),
      .hit_o          (way_hit[w]),
      .tag_o          (way_tag[w]),
      .dirty_o        (way_dirty[w]),
      .line_o         (way_line[w])
    );
  end

  dcache_way_select u_sel (
    .clk            (clk),
    .rst            (rst),
    .hit_i          (way_hit),
    .tag_i          (way_tag),
    .dirty_i        (way_dirty),
    .line_i         (way_line),
    .sel_way_i      (sel_way),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),
    .line_o         (sel_line)
  );

  dcache_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .rd_req_valid_i  (rd_req_valid_i),
    .rd_req_ready_o  (rd_req_ready_o),
    .rd_req_addr_i   (rd_req_addr_i),
    .rd_rsp_valid_o  (rd_rsp_valid_o),
    .rd_rsp_ready_i  (rd_rsp_ready_i),
    .rd_rsp_data_o   (rd_rsp_data_o),
    .wr_req_valid_i  (wr_req_valid_i),
    .wr_req_ready_o  (wr_req_ready_o),
    .wr_req_addr_i   (wr_req_addr_i),
    .wr_data_valid_i (wr_data_valid_i),
    .wr_data_ready_o (wr_data_ready_o),
    .wr_data_i       (wr_data_i),
    .wr_done_valid_o (wr_done_valid_o),
    .wr_done_ready_i (wr_done_ready_i),
    .mem_ar_valid_o  (mem_ar_valid_o),
    .mem_ar_ready_i  (mem_ar_ready_i),
    .mem_ar_addr_o   (mem_ar_addr_o),
    .mem_r_valid_i   (mem_r_valid_i),
    .mem_r_ready_o   (mem_r_ready_o),
    .mem_r_i         (mem_r_i),
    .mem_aw_valid_o  (mem_aw_valid_o),
    .mem_aw_ready_i  (mem_aw_ready_i),
    .mem_aw_addr_o   (mem_aw_addr_o),
    .mem_w_valid_o   (mem_w_valid_o),
    .mem_w_ready_i   (mem_w_ready_i),
    .mem_w_o         (mem_w_o),
    .mem_b_valid_i   (mem_b_valid_i),
    .mem_b_ready_o   (mem_b_ready_o),
    .lookup_index_o  (lookup_index),
    .lookup_tag_o    (lookup_tag),
    .way_wr_o        (way_wr),
    .way_wr_en_o     (way_wr_en),
    .sel_way_o       (sel_way),
    .hit_i           (hit),
    .hit_way_i       (hit_way),
    .victim_way_i    (victim_way),
    .victim_dirty_i  (victim_dirty),
    .victim_tag_i    (victim_tag),
    .line_i          (sel_line)
  );

endmodule

`default_nettype wire

//--- test/dcache_mem_model.sv
`default_nettype none

module dcache_mem_model (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            mem_ar_valid_i,
  output logic                           mem_ar_ready_o,
  input  wire dcache_addr_pkg::addr_t    mem_ar_addr_i,
  output logic                           mem_r_valid_o,
  input  wire                            mem_r_ready_i,
  output dcache_bus_pkg::mem_r_t         mem_r_o,
  input  wire                            mem_aw_valid_i,
  output logic                           mem_aw_ready_o,
  input  wire dcache_addr_pkg::addr_t    mem_aw_addr_i,
  input  wire                            mem_w_valid_i,
  output logic                           mem_w_ready_o,
  input  wire dcache_bus_pkg::mem_w_t    mem_w_i,
  output logic                           mem_b_valid_o,
  input  wire                            mem_b_ready_i,
  output int                             errors_o
);
  timeunit 1ns;
  timeprecision 100ps;

  dcache_addr_pkg::word_t store [dcache_addr_pkg::addr_t];  // written lines only
  dcache_addr_pkg::addr_t ar_sample, aw_sample, rd_ptr, wr_ptr;
  dcache_bus_pkg::mem_w_t w_sample;
  logic [31:0] rnd;
  logic ar_x, r_x, aw_x, w_x, b_x;
  logic rd_busy, wr_busy, wr_resp;
  int rd_left, wr_beat;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // untouched words read back as {~A, A}
  function automatic dcache_addr_pkg::word_t fetch(input dcache_addr_pkg::addr_t a);
    if (store.exists(a)) begin
      return store[a];
    end
    return {~a, a};
  endfunction

  initial begin
    mem_ar_ready_o = 1'b0;
    mem_r_valid_o = 1'b0;
    mem_r_o = '0;
    mem_aw_ready_o = 1'b0;
    mem_w_ready_o = 1'b0;
    mem_b_valid_o = 1'b0;
    errors_o = 0;
    rnd = 32'h3b456f14;
    rd_busy = 1'b0;
    wr_busy = 1'b0;
    wr_resp = 1'b0;
    rd_left = 0;
    wr_beat = 0;
    rd_ptr = '0;
    wr_ptr = '0;
    forever begin
      // handshakes seen before the edge
      @(negedge clk);
      ar_x = mem_ar_valid_i && mem_ar_ready_o;
      r_x = mem_r_valid_o && mem_r_ready_i;
      aw_x = mem_aw_valid_i && mem_aw_ready_o;
      w_x = mem_w_valid_i && mem_w_ready_o;
      b_x = mem_b_valid_o && mem_b_ready_i;
      ar_sample = mem_ar_addr_i;
      aw_sample = mem_aw_addr_i;
      w_sample = mem_w_i;
      @(posedge clk);
      #2;
      rnd = xorshift32(rnd);
      if (rst) begin
        rd_busy = 1'b0;
        wr_busy = 1'b0;
        wr_resp = 1'b0;
      end else begin
        if (ar_x) begin
          assert (ar_sample[3:0] == 4'h0) else begin
            errors_o++;
            $display("read address %h at %0t is not line-aligned", ar_sample, $time);
          end
          rd_ptr = ar_sample;
          rd_left = 2;
          rd_busy = 1'b1;
        end
        if (r_x) begin
          rd_ptr = rd_ptr + 32'd8;
          rd_left--;
          rd_busy = rd_left != 0;
        end
        if (aw_x) begin
          assert (aw_sample[3:0] == 4'h0) else begin
            errors_o++;
            $display("write address %h at %0t is not line-aligned", aw_sample, $time);
          end
          wr_ptr = aw_sample;
          wr_beat = 0;
          wr_busy = 1'b1;
        end
        if (w_x) begin
          assert (w_sample.last == (wr_beat == 1)) else begin
            errors_o++;
            $display("write beat %0d at %0t has last=%b, bursts are two beats",
                     wr_beat, $time, w_sample.last);
          end
          store[wr_ptr] = w_sample.data;
          wr_ptr = wr_ptr + 32'd8;
          wr_beat++;
          if (wr_beat == 2) begin
            wr_busy = 1'b0;
            wr_resp = 1'b1;
          end
        end
        if (b_x) wr_resp = 1'b0;
      end
      mem_ar_ready_o = !rst && !rd_busy && rnd[1:0] != 2'b00;
      if (!rd_busy) begin
        mem_r_valid_o = 1'b0;
      end else if (!mem_r_valid_o || r_x) begin
        mem_r_valid_o = rnd[3:2] != 2'b00;  // valid holds until taken
      end
      mem_r_o.data = fetch(rd_ptr);
      mem_r_o.last = rd_left == 1;
      mem_aw_ready_o = !rst && !wr_busy && !wr_resp && rnd[5:4] != 2'b00;
      mem_w_ready_o = wr_busy && rnd[7:6] != 2'b00;
      if (!wr_resp) begin
        mem_b_valid_o = 1'b0;
      end else if (!mem_b_valid_o) begin
        mem_b_valid_o = rnd[9:8] != 2'b00;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/dcache_tb.sv
`default_nettype none

module dcache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 6 * 40 * 60;

  logic clk, rst;
  logic rd_req_valid, rd_req_ready, rd_rsp_valid, rd_rsp_ready;
  logic wr_req_valid, wr_req_ready, wr_data_valid, wr_data_ready;
  logic wr_done_valid, wr_done_ready;
  dcache_addr_pkg::addr_t rd_req_addr, wr_req_addr;
  dcache_addr_pkg::word_t rd_rsp_data;
  dcache_bus_pkg::wr_data_t wr_data;
  logic mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
  logic mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready;
  logic mem_b_valid, mem_b_ready;
  dcache_addr_pkg::addr_t mem_ar_addr, mem_aw_addr;
  dcache_bus_pkg::mem_r_t mem_r;
  dcache_bus_pkg::mem_w_t mem_w;

  dcache_addr_pkg::word_t expect_mem [dcache_addr_pkg::addr_t];  // written words only
  dcache_addr_pkg::addr_t wb_ptr, last_ar;
  logic [31:0] rnd_state;
  logic hold_rsp;  // random back-pressure on responses
  int unsigned cycle;
  int errors, checks, mem_errors, test_start;
  int ar_count, aw_count, done_count, writes;

  dcache_top DUT (
    .clk(clk), .rst(rst),
    .rd_req_valid_i(rd_req_valid), .rd_req_ready_o(rd_req_ready),
    .rd_req_addr_i(rd_req_addr),
    .rd_rsp_valid_o(rd_rsp_valid), .rd_rsp_ready_i(rd_rsp_ready),
    .rd_rsp_data_o(rd_rsp_data),
    .wr_req_valid_i(wr_req_valid), .wr_req_ready_o(wr_req_ready),
    .wr_req_addr_i(wr_req_addr),
    .wr_data_valid_i(wr_data_valid), .wr_data_ready_o(wr_data_ready),
    .wr_data_i(wr_data),
    .wr_done_valid_o(wr_done_valid), .wr_done_ready_i(wr_done_ready),
    .mem_ar_valid_o(mem_ar_valid), .mem_ar_ready_i(mem_ar_ready),
    .mem_ar_addr_o(mem_ar_addr),
    .mem_r_valid_i(mem_r_valid), .mem_r_ready_o(mem_r_ready), .mem_r_i(mem_r),
    .mem_aw_valid_o(mem_aw_valid), .mem_aw_ready_i(mem_aw_ready),
    .mem_aw_addr_o(mem_aw_addr),
    .mem_w_valid_o(mem_w_valid), .mem_w_ready_i(mem_w_ready), .mem_w_o(mem_w),
    .mem_b_valid_i(mem_b_valid), .mem_b_ready_o(mem_b_ready)
  );

  dcache_mem_model u_mem (
    .clk(clk), .rst(rst),
    .mem_ar_valid_i(mem_ar_valid), .mem_ar_ready_o(mem_ar_ready),
    .mem_ar_addr_i(mem_ar_addr),
    .mem_r_valid_o(mem_r_valid), .mem_r_ready_i(mem_r_ready), .mem_r_o(mem_r),
    .mem_aw_valid_i(mem_aw_valid), .mem_aw_ready_o(mem_aw_ready),
    .mem_aw_addr_i(mem_aw_addr),
    .mem_w_valid_i(mem_w_valid), .mem_w_ready_o(mem_w_ready), .mem_w_i(mem_w),
    .mem_b_valid_o(mem_b_valid), .mem_b_ready_i(mem_b_ready),
    .errors_o(mem_errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rnd_state = xorshift32(rnd_state);
    return rnd_state;
  endfunction

  function automatic dcache_addr_pkg::word_t expected_word(input dcache_addr_pkg::addr_t a);
    dcache_addr_pkg::addr_t w;
    w = {a[31:3], 3'b000};
    if (expect_mem.exists(w)) begin
      return expect_mem[w];
    end
    return {~w, w};
  endfunction

  function automatic dcache_addr_pkg::word_t merge_bytes(input dcache_addr_pkg::word_t old,
                                                         input dcache_addr_pkg::word_t data,
                                                         input dcache_addr_pkg::strb_t strb);
    dcache_addr_pkg::word_t r;
    r = old;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) r[b*8 +: 8] = data[b*8 +: 8];
    end
    return r;
  endfunction

  function automatic dcache_addr_pkg::addr_t make_addr(input logic [21:0] tag,
                                                       input logic [5:0] index,
                                                       input logic word);
    return {tag, index, word, 3'b000};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic cpu_read(input dcache_addr_pkg::addr_t addr, input logic check_lat);
    dcache_addr_pkg::word_t held;
    logic seen, done;
    int unsigned acc_edge;
    rd_req_valid = 1'b1;
    rd_req_addr = addr;
    done = 1'b0;
    acc_edge = 0;
    while (!done) begin
      @(negedge clk);
      done = rd_req_ready;
      acc_edge = cycle + 1;  // edge that takes the request
      @(posedge clk);
      #2;
    end
    rd_req_valid = 1'b0;
    seen = 1'b0;
    done = 1'b0;
    held = '0;
    while (!done) begin
      @(negedge clk);
      if (seen) begin
        check_value("rd_rsp_valid_o", rd_rsp_valid, 1'b1);
        check_value("rd_rsp_data_o", rd_rsp_data, held);
      end else if (rd_rsp_valid) begin
        seen = 1'b1;
        held = rd_rsp_data;
        if (check_lat) check_value("rd_rsp_valid_o latency", cycle - acc_edge, 2);
      end
      done = seen && rd_rsp_ready;
      @(posedge clk);
      #2;
      rd_rsp_ready = hold_rsp ? next_rand() % 4 == 0 : 1'b1;
    end
    check_value("rd_rsp_data_o", held, expected_word(addr));
  endtask

  task automatic cpu_write(input dcache_addr_pkg::addr_t addr,
                           input dcache_addr_pkg::word_t data,
                           input dcache_addr_pkg::strb_t strb);
    logic req_done, data_done, done;
    wr_req_valid = 1'b1;
    wr_req_addr = addr;
    wr_data_valid = 1'b1;
    wr_data.data = data;
    wr_data.strb = strb;
    req_done = 1'b0;
    data_done = 1'b0;
    while (!(req_done && data_done)) begin
      @(negedge clk);
      if (wr_req_valid && wr_req_ready) req_done = 1'b1;
      if (wr_data_valid && wr_data_ready) data_done = 1'b1;
      @(posedge clk);
      #2;
      if (req_done) wr_req_valid = 1'b0;
      if (data_done) wr_data_valid = 1'b0;
    end
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = wr_done_valid && wr_done_ready;
      @(posedge clk);
      #2;
      wr_done_ready = hold_rsp ? next_rand() % 4 == 0 : 1'b1;
    end
    writes++;
    expect_mem[{addr[31:3], 3'b000}] = merge_bytes(expected_word(addr), data, strb);
  endtask

  task automatic finish_test(input int num, input string name);
    int failed;
    repeat (3) @(posedge clk);
    #2;
    check_value("wr_done_valid_o transfers", done_count, writes);
    failed = errors + mem_errors - test_start;
    $display("test %0d %s: %s, %0d errors", num, name, failed == 0 ? "ok" : "failed", failed);
    test_start = errors + mem_errors;
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // count memory traffic and check writeback data against the shadow
  always @(negedge clk) begin
    if (!rst) begin
      if (mem_ar_valid && mem_ar_ready) begin
        ar_count++;
        last_ar = mem_ar_addr;
      end
      if (mem_aw_valid && mem_aw_ready) begin
        aw_count++;
        wb_ptr = mem_aw_addr;
      end
      if (mem_w_valid && mem_w_ready) begin
        check_value("mem_w_o.data", mem_w.data, expected_word(wb_ptr));
        wb_ptr = wb_ptr + 32'd8;
      end
      if (wr_done_valid && wr_done_ready) done_count++;
    end
  end

  initial begin
    dcache_addr_pkg::addr_t a0, a;
    dcache_addr_pkg::word_t d;
    logic [31:0] r;
    int ar_before, aw_before, total;
    cycle = 0;
    errors = 0;
    checks = 0;
    test_start = 0;
    ar_count = 0;
    aw_count = 0;
    done_count = 0;
    writes = 0;
    rnd_state = 32'h3b456f14;
    hold_rsp = 1'b0;
    wb_ptr = '0;
    last_ar = '0;
    rst = 1'b1;
    rd_req_valid = 1'b0;
    rd_req_addr = '0;
    rd_rsp_ready = 1'b1;
    wr_req_valid = 1'b0;
    wr_req_addr = '0;
    wr_data_valid = 1'b0;
    wr_data = '0;
    wr_done_ready = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    @(negedge clk);
    check_value("rd_req_ready_o", rd_req_ready, 1'b1);
    check_value("wr_req_ready_o", wr_req_ready, 1'b1);
    check_value("rd_rsp_valid_o", rd_rsp_valid, 1'b0);
    check_value("wr_data_ready_o", wr_data_ready, 1'b0);
    check_value("wr_done_valid_o", wr_done_valid, 1'b0);
    check_value("mem_ar_valid_o", mem_ar_valid, 1'b0);
    check_value("mem_r_ready_o", mem_r_ready, 1'b0);
    check_value("mem_aw_valid_o", mem_aw_valid, 1'b0);
    check_value("mem_w_valid_o", mem_w_valid, 1'b0);
    check_value("mem_b_ready_o", mem_b_ready, 1'b0);
    @(posedge clk);
    #2;
    finish_test(1, "reset state");

    a0 = make_addr(22'h00004d, 6'h23, 1'b1);
    ar_before = ar_count;
    cpu_read(a0, 1'b0);
    check_value("memory read requests", ar_count - ar_before, 1);
    check_value("mem_ar_addr_o", last_ar, {a0[31:4], 4'h0});
    finish_test(2, "cold read");

    ar_before = ar_count;
    aw_before = aw_count;
    cpu_read(a0, 1'b1);
    cpu_read(a0, 1'b1);
    check_value("memory reads on hit", ar_count - ar_before, 0);
    check_value("memory writes on hit", aw_count - aw_before, 0);
    finish_test(3, "read hit");

    cpu_write(a0, 64'h0123_4567_89ab_cdef, 8'b0011_0101);
    cpu_read(a0, 1'b1);
    check_value("memory reads on write hit", ar_count - ar_before, 0);
    finish_test(4, "write hit with strobe");

    aw_before = aw_count;
    cpu_write(make_addr(22'h0000a1, 6'h15, 1'b0), 64'h1111_2222_3333_4444, 8'hff);
    cpu_write(make_addr(22'h0000b2, 6'h15, 1'b1), 64'h5555_6666_7777_8888, 8'hff);
    cpu_write(make_addr(22'h0000c3, 6'h15, 1'b0), 64'h9999_aaaa_bbbb_cccc, 8'hf0);
    check_value("eviction writeback seen", aw_count > aw_before, 1'b1);
    cpu_read(make_addr(22'h0000a1, 6'h15, 1'b0), 1'b0);
    cpu_read(make_addr(22'h0000b2, 6'h15, 1'b1), 1'b0);
    cpu_read(make_addr(22'h0000c3, 6'h15, 1'b0), 1'b0);
    cpu_read(make_addr(22'h0000a1, 6'h15, 1'b1), 1'b0);
    cpu_read(make_addr(22'h0000b2, 6'h15, 1'b0), 1'b0);
    cpu_read(make_addr(22'h0000c3, 6'h15, 1'b1), 1'b0);
    finish_test(5, "dirty eviction");

    hold_rsp = 1'b1;
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      a = make_addr(22'h000100 + {20'h0, r[1:0]}, {4'h0, r[3:2]}, r[4]);  // 4 tags, 4 sets
      if (r[5]) begin
        d = {next_rand(), next_rand()};
        r = next_rand();
        cpu_write(a, d, r[7:0]);
      end else begin
        cpu_read(a, 1'b0);
      end
    end
    hold_rsp = 1'b0;
    rd_rsp_ready = 1'b1;
    wr_done_ready = 1'b1;
    finish_test(6, "random traffic");

    total = errors + mem_errors;
    $display("6 tests, %0d checks, %0d errors", checks, total);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache.f
+incdir+.
logic/dcache_addr_pkg.sv
logic/dcache_bus_pkg.sv
logic/dcache_way.sv
logic/dcache_way_select.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dcache testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
  -f dcache.f -o dcache_sim
out=$(./obj_dir/dcache_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1
